//--- hw/lcd_timing_pkg.sv
// Timing constants for the LCD controller at a 50 MHz CLK
// Delay cycle counts, timer width and bus writer phase codes

package lcd_timing_pkg;

	// ---------------------------------------------------------------------------
	// Clock and derived cycle counts
	// ---------------------------------------------------------------------------
	localparam logic [31:0] CLK_FREQ_HZ = 32'd50_000_000;              // 50 MHz system clock
	localparam logic [31:0] CYC_PER_US  = CLK_FREQ_HZ / 32'd1_000_000; // 50 cycles per us

	localparam logic [31:0] POWERUP_CYCLES    = CYC_PER_US * 32'd50_000; // 50 ms panel power-up
	localparam logic [31:0] E_HIGH_CYCLES     = (CYC_PER_US * 32'd250 + 32'd999) / 32'd1000; // 250 ns
	localparam logic [31:0] WAIT_CHAR_CYCLES  = (CYC_PER_US * 32'd250 + 32'd999) / 32'd1000; // 250 ns
	localparam logic [31:0] WAIT_SHORT_CYCLES = CYC_PER_US * 32'd42;     // 42 us, most instructions
	localparam logic [31:0] WAIT_FUNC_CYCLES  = CYC_PER_US * 32'd100;    // 100 us, function set
	localparam logic [31:0] WAIT_LONG_CYCLES  = CYC_PER_US * 32'd1640;   // 1.64 ms, clear and home

	// Longest load is the power-up wait, 22 bits
	localparam int TIMER_W = $clog2(POWERUP_CYCLES + 1);

	// ---------------------------------------------------------------------------
	// Bus writer phases
	// ---------------------------------------------------------------------------
	localparam logic [1:0] PH_POWERUP = 2'd0; // Waiting out panel power-up
	localparam logic [1:0] PH_IDLE    = 2'd1; // Ready for the next word
	localparam logic [1:0] PH_STROBE  = 2'd2; // E held high
	localparam logic [1:0] PH_EXEC    = 2'd3; // Panel busy with the last word

endpackage

//--- hw/lcd_cmd_pkg.sv
// Command side of the LCD controller
// Request codes, HD44780 command bytes, init table, bus word view, execution classes
// FIFO sizing

package lcd_cmd_pkg;

	// ---------------------------------------------------------------------------
	// Host request codes
	// ---------------------------------------------------------------------------
	localparam logic [1:0] OPER_NONE   = 2'd0; // Accepted, no bus word
	localparam logic [1:0] OPER_CHAR   = 2'd1; // Character write, RS high
	localparam logic [1:0] OPER_INSTR  = 2'd2; // Instruction write, RS low
	localparam logic [1:0] OPER_REINIT = 2'd3; // Resend init sequence

	// ---------------------------------------------------------------------------
	// Command bytes
	// ---------------------------------------------------------------------------
	localparam logic [7:0] CMD_FUNC_SET     = 8'b0011_1100; // 8-bit bus, 2 lines, 5x11 font
	localparam logic [7:0] CMD_DISP_OFF     = 8'b0000_1000; // Display, cursor, blink off
	localparam logic [7:0] CMD_CLEAR        = 8'b0000_0001; // Clear DDRAM, cursor home
	localparam logic [7:0] CMD_ENTRY_NORMAL = 8'b0000_0110; // Increment, no shift
	localparam logic [7:0] CMD_DISP_ON      = 8'b0000_1100; // Display on, cursor off

	// ---------------------------------------------------------------------------
	// Init sequence, entry 0 goes out first
	// ---------------------------------------------------------------------------
	localparam int INIT_LEN   = 7;
	localparam int INIT_IDX_W = $clog2(INIT_LEN);

	localparam logic [INIT_IDX_W-1:0] INIT_LAST = INIT_IDX_W'(INIT_LEN - 1); // Last table index

	localparam logic [0:INIT_LEN-1][7:0] INIT_TABLE = {
		CMD_FUNC_SET,     // Function set twice
		CMD_FUNC_SET,
		CMD_DISP_OFF,
		CMD_CLEAR,
		CMD_ENTRY_NORMAL,
		CMD_DISP_ON,
		CMD_CLEAR
	};

	// ---------------------------------------------------------------------------
	// Bus word, read as instruction flags or as a character code
	// ---------------------------------------------------------------------------
	typedef union packed {
		struct packed {
			logic set_ddram;  // Bit 7, DDRAM address
			logic set_cgram;  // Bit 6, CGRAM address
			logic func_set;   // Bit 5, function set
			logic shift;      // Bit 4, cursor or display shift
			logic disp_ctrl;  // Bit 3, display on/off control
			logic entry_mode; // Bit 2, entry mode set
			logic home;       // Bit 1, return home
			logic clear;      // Bit 0, clear display
		} instr;
		logic [7:0] char_code; // Character code for RS high
	} lcd_word_u;

	// Execution wait after a word
	typedef enum logic [1:0] {
		EXEC_CHAR,
		EXEC_SHORT,
		EXEC_FUNC,
		EXEC_LONG
	} exec_class_e;

	// Command FIFO sizing
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2;
	localparam int FIFO_CNT_W = 3; // Holds 0 to FIFO_DEPTH

endpackage

//--- hw/lcd_sequencer.sv
`timescale 1ns/100ps
// Request sequencer for the LCD controller
// Walks the init table after reset or on replay, then passes host requests through

module lcd_sequencer (
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   req_valid,  // Host request
	input  logic [1:0]             req_oper,
	input  logic [7:0]             req_data,
	output logic                   req_ready,
	output logic                   out_valid,  // Word toward command FIFO
	output logic                   out_rs,
	output lcd_cmd_pkg::lcd_word_u out_word,
	input  logic                   out_ready
);

	logic                               init_mode; // 1 while walking the init table
	logic [lcd_cmd_pkg::INIT_IDX_W-1:0] init_idx;  // Next table entry
	logic                               out_free;  // Output register empty or draining
	logic                               req_fire;  // Host transfer this cycle
	logic                               req_word;  // Transfer carries a bus word

	assign out_free  = !out_valid || out_ready;
	assign req_ready = !init_mode && out_free;  // Host held off during the table walk
	assign req_fire  = req_valid && req_ready;
	assign req_word  = (req_oper == lcd_cmd_pkg::OPER_CHAR) ||
		(req_oper == lcd_cmd_pkg::OPER_INSTR);

	// ---------------------------------------------------------------------------
	// Mode and table index
	// ---------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			init_mode <= 1'b1;                           // Init sequence first
			init_idx  <= '0;
		end else if (init_mode && out_free) begin
			if (init_idx == lcd_cmd_pkg::INIT_LAST) begin
				init_mode <= 1'b0;                       // Table done, hand over to host
				init_idx  <= '0;
			end else begin
				init_idx <= init_idx + 1'b1;
			end
		end else if (req_fire && (req_oper == lcd_cmd_pkg::OPER_REINIT)) begin
			init_mode <= 1'b1;                           // Replay from entry 0
			init_idx  <= '0;
		end
	end

	// Output register valid
	always_ff @(posedge CLK) begin
		if (RST) begin
			out_valid <= 1'b0;
		end else if (out_free) begin
			out_valid <= init_mode || (req_fire && req_word);
		end
	end

	// Output register payload, only loaded when free
	always_ff @(posedge CLK) begin
		if (out_free) begin
			if (init_mode) begin
				out_rs   <= 1'b0;                        // Table holds instructions only
				out_word <= lcd_cmd_pkg::INIT_TABLE[init_idx];
			end else if (req_fire) begin
				case (req_oper)
					lcd_cmd_pkg::OPER_CHAR: begin
						out_rs             <= 1'b1;      // Data register
						out_word.char_code <= req_data;
					end
					lcd_cmd_pkg::OPER_INSTR: begin
						out_rs   <= 1'b0;                // Instruction register
						out_word <= req_data;
					end
					lcd_cmd_pkg::OPER_NONE, lcd_cmd_pkg::OPER_REINIT: begin
						out_rs <= out_rs;                // No word, valid drops
					end
				endcase
			end
		end
	end

	// ---------------------------------------------------------------------------
	// Checks
	// ---------------------------------------------------------------------------
	// A stalled word stays put until the FIFO takes it
	a_out_stable: assert property (@(posedge CLK) disable iff (RST)
		out_valid && !out_ready |=> out_valid && $stable(out_rs) && $stable(out_word))
		else $error("lcd_sequencer output changed under back-pressure");

endmodule

//--- hw/lcd_cmd_fifo.sv
`timescale 1ns/100ps
// Four-entry command FIFO between sequencer and bus writer
// Circular buffer with read and write pointers and an occupancy count

module lcd_cmd_fifo (
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   in_valid,  // From sequencer
	input  logic                   in_rs,
	input  lcd_cmd_pkg::lcd_word_u in_word,
	output logic                   in_ready,
	output logic                   out_valid, // To bus writer
	output logic                   out_rs,
	output lcd_cmd_pkg::lcd_word_u out_word,
	input  logic                   out_ready
);

	logic                               mem_rs   [lcd_cmd_pkg::FIFO_DEPTH]; // Storage
	lcd_cmd_pkg::lcd_word_u             mem_word [lcd_cmd_pkg::FIFO_DEPTH];
	logic [lcd_cmd_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [lcd_cmd_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [lcd_cmd_pkg::FIFO_CNT_W-1:0] count;
	logic                               push;
	logic                               pop;

	assign in_ready  = count != lcd_cmd_pkg::FIFO_DEPTH; // Full at four
	assign out_valid = count != '0;
	assign out_rs    = mem_rs[rd_ptr];                     // Head of queue
	assign out_word  = mem_word[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// Storage write
	always_ff @(posedge CLK) begin
		if (push) begin
			mem_rs[wr_ptr]   <= in_rs;
			mem_word[wr_ptr] <= in_word;
		end
	end

	// ---------------------------------------------------------------------------
	// Pointers and count
	// ---------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;            // Wraps at four
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;                  // Idle or push with pop
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// Checks
	// ---------------------------------------------------------------------------
	a_count_max: assert property (@(posedge CLK) disable iff (RST)
		count <= lcd_cmd_pkg::FIFO_DEPTH)
		else $error("lcd_cmd_fifo count above depth");

	// Read side stands still while empty
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (RST)
		count == '0 |=> rd_ptr == $past(rd_ptr))
		else $error("lcd_cmd_fifo popped while empty");

endmodule

//--- hw/lcd_bus_writer.sv
`timescale 1ns/100ps
// Panel bus writer for the LCD controller
// Power-up wait, E strobe and per-word execution wait on one down-counter

module lcd_bus_writer (
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   in_valid, // From command FIFO
	input  logic                   in_rs,
	input  lcd_cmd_pkg::lcd_word_u in_word,
	output logic                   in_ready,
	output logic                   lcd_e,    // Panel pins
	output logic                   lcd_rs,
	output logic [7:0]             lcd_db
);

	logic [1:0]                          state;
	logic [lcd_timing_pkg::TIMER_W-1:0]  timer;      // Cycles left in current phase
	lcd_cmd_pkg::exec_class_e            in_class;   // Class of the word on the input
	lcd_cmd_pkg::exec_class_e            exec_class; // Class of the word on the bus
	logic [31:0]                         exec_len;   // Wait for exec_class
	logic                                accept;

	assign in_ready = state == lcd_timing_pkg::PH_IDLE;
	assign accept   = in_valid && in_ready;

	// ---------------------------------------------------------------------------
	// Word classification, highest instruction flag wins
	// ---------------------------------------------------------------------------
	always_comb begin
		if (in_rs) begin
			in_class = lcd_cmd_pkg::EXEC_CHAR;
		end else if (in_word.instr.set_ddram || in_word.instr.set_cgram) begin
			in_class = lcd_cmd_pkg::EXEC_SHORT;
		end else if (in_word.instr.func_set) begin
			in_class = lcd_cmd_pkg::EXEC_FUNC;
		end else if (in_word.instr.shift || in_word.instr.disp_ctrl ||
			in_word.instr.entry_mode) begin
			in_class = lcd_cmd_pkg::EXEC_SHORT;
		end else if (in_word.instr.home || in_word.instr.clear) begin
			in_class = lcd_cmd_pkg::EXEC_LONG;             // Clear and home are slow
		end else begin
			in_class = lcd_cmd_pkg::EXEC_SHORT;            // Null byte
		end
	end

	always_comb begin
		case (exec_class)
			lcd_cmd_pkg::EXEC_CHAR:  exec_len = lcd_timing_pkg::WAIT_CHAR_CYCLES;
			lcd_cmd_pkg::EXEC_SHORT: exec_len = lcd_timing_pkg::WAIT_SHORT_CYCLES;
			lcd_cmd_pkg::EXEC_FUNC:  exec_len = lcd_timing_pkg::WAIT_FUNC_CYCLES;
			default:                 exec_len = lcd_timing_pkg::WAIT_LONG_CYCLES;
		endcase
	end

	// Class held for the execute phase
	always_ff @(posedge CLK) begin
		if (accept) exec_class <= in_class;
	end

	// ---------------------------------------------------------------------------
	// Phase FSM
	// ---------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			state  <= lcd_timing_pkg::PH_POWERUP;          // Power-up wait starts here
			timer  <= lcd_timing_pkg::POWERUP_CYCLES[lcd_timing_pkg::TIMER_W-1:0] - 1'b1;
			lcd_e  <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_db <= '0;
		end else begin
			case (state)
				lcd_timing_pkg::PH_POWERUP: begin
					if (timer == '0) state <= lcd_timing_pkg::PH_IDLE;
					else timer <= timer - 1'b1;
				end
				lcd_timing_pkg::PH_IDLE: begin
					if (accept) begin
						state  <= lcd_timing_pkg::PH_STROBE;
						timer  <= lcd_timing_pkg::E_HIGH_CYCLES[lcd_timing_pkg::TIMER_W-1:0] - 1'b1;
						lcd_e  <= 1'b1;                    // RS and DB set with the rising edge
						lcd_rs <= in_rs;
						lcd_db <= in_word;
					end
				end
				lcd_timing_pkg::PH_STROBE: begin
					if (timer == '0) begin
						state <= lcd_timing_pkg::PH_EXEC;
						timer <= exec_len[lcd_timing_pkg::TIMER_W-1:0] - 1'b1;
						lcd_e <= 1'b0;                     // Panel latches on falling E
					end else begin
						timer <= timer - 1'b1;
					end
				end
				default: begin                             // Execute wait
					if (timer == '0) state <= lcd_timing_pkg::PH_IDLE;
					else timer <= timer - 1'b1;
				end
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// Checks
	// ---------------------------------------------------------------------------
	a_e_in_strobe: assert property (@(posedge CLK) disable iff (RST)
		lcd_e |-> state == lcd_timing_pkg::PH_STROBE)
		else $error("lcd_bus_writer E high outside strobe");

	// Bus steady across the whole strobe
	a_bus_steady: assert property (@(posedge CLK) disable iff (RST)
		lcd_e |=> !lcd_e || ($stable(lcd_db) && $stable(lcd_rs)))
		else $error("lcd_bus_writer bus changed while E high");

endmodule

//--- hw/lcd_ctrl_top.sv
`timescale 1ns/100ps
// Top level of the LCD controller
// Sequencer, command FIFO and bus writer between host request and panel pins

module lcd_ctrl_top (
	input  logic       CLK,
	input  logic       RST,
	input  logic       req_valid, // Host request
	input  logic [1:0] req_oper,
	input  logic [7:0] req_data,
	output logic       req_ready,
	output logic       lcd_e,     // Panel pins, RW tied low on board
	output logic       lcd_rs,
	output logic [7:0] lcd_db
);

	// Sequencer to FIFO
	logic                   seq_valid;
	logic                   seq_rs;
	lcd_cmd_pkg::lcd_word_u seq_word;
	logic                   seq_ready;

	// FIFO to bus writer
	logic                   wr_valid;
	logic                   wr_rs;
	lcd_cmd_pkg::lcd_word_u wr_word;
	logic                   wr_ready;

	// ---------------------------------------------------------------------------
	// Producer, buffer, consumer
	// ---------------------------------------------------------------------------
	lcd_sequencer i_sequencer (
		.CLK       (CLK),
		.RST       (RST),
		.req_valid (req_valid),
		.req_oper  (req_oper),
		.req_data  (req_data),
		.req_ready (req_ready),
		.out_valid (seq_valid),
		.out_rs    (seq_rs),
		.out_word  (seq_word),
		.out_ready (seq_ready)
	);

	lcd_cmd_fifo i_cmd_fifo (
		.CLK       (CLK),
		.RST       (RST),
		.in_valid  (seq_valid),
		.in_rs     (seq_rs),
		.in_word   (seq_word),
		.in_ready  (seq_ready),
		.out_valid (wr_valid),
		.out_rs    (wr_rs),
		.out_word  (wr_word),
		.out_ready (wr_ready)
	);

	lcd_bus_writer i_bus_writer (
		.CLK      (CLK),
		.RST      (RST),
		.in_valid (wr_valid),
		.in_rs    (wr_rs),
		.in_word  (wr_word),
		.in_ready (wr_ready),
		.lcd_e    (lcd_e),
		.lcd_rs   (lcd_rs),
		.lcd_db   (lcd_db)
	);

endmodule

//--- dv/lcd_bus_checker.sv
`timescale 1ns/100ps
// Panel pin monitor for the LCD controller testbench
// Expected word queue, strobe shape, execution gap and word order checks

module lcd_bus_checker (
	input  logic       CLK,
	input  logic       RST,
	input  logic       lcd_e,       // Panel pins under watch
	input  logic       lcd_rs,
	input  logic [7:0] lcd_db,
	input  logic       req_ready,
	output int         error_count,
	output int         words_seen
);

	logic                     exp_rs_q  [$]; // Expected words, oldest first
	logic [7:0]               exp_db_q  [$];
	lcd_cmd_pkg::exec_class_e exp_cls_q [$];

	logic                     e_prev;
	logic                     after_rst;     // First sample out of reset
	logic                     hold_rs;       // Bus value taken at the E rise
	logic [7:0]               hold_db;
	lcd_cmd_pkg::exec_class_e cur_cls;       // Class of the word on the bus
	int                       low_cycles;    // Samples with E low since last fall
	int                       high_cycles;   // Samples with E high in this strobe
	int                       need_gap;      // Minimum low samples before next rise

	// Called by the testbench for every word it expects
	task automatic expect_word(input logic rs, input logic [7:0] db,
		input lcd_cmd_pkg::exec_class_e cls);
		exp_rs_q.push_back(rs);
		exp_db_q.push_back(db);
		exp_cls_q.push_back(cls);
	endtask

	// Execution wait per class, in cycles
	function automatic int class_wait(input lcd_cmd_pkg::exec_class_e cls);
		case (cls)
			lcd_cmd_pkg::EXEC_CHAR:  return int'(lcd_timing_pkg::WAIT_CHAR_CYCLES);
			lcd_cmd_pkg::EXEC_SHORT: return int'(lcd_timing_pkg::WAIT_SHORT_CYCLES);
			lcd_cmd_pkg::EXEC_FUNC:  return int'(lcd_timing_pkg::WAIT_FUNC_CYCLES);
			default:                 return int'(lcd_timing_pkg::WAIT_LONG_CYCLES);
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// Pin sampling, all on the rising edge
	// ------------------------------------------------------------------------
	always @(posedge CLK) begin
		if (RST) begin
			e_prev      = 1'b0;
			after_rst   = 1'b1;
			low_cycles  = 0;
			high_cycles = 0;
			need_gap    = int'(lcd_timing_pkg::POWERUP_CYCLES); // Power-up wait first
			cur_cls     = lcd_cmd_pkg::EXEC_LONG;
		end else begin
			if (after_rst) begin                 // Reset values on all outputs
				after_rst = 1'b0;
				if (lcd_e !== 1'b0 || lcd_rs !== 1'b0 || lcd_db !== 8'h00 || req_ready !== 1'b0) begin
					$display("error: outputs after reset e=0x%h rs=0x%h db=0x%h ready=0x%h, expected 0x0",
						lcd_e, lcd_rs, lcd_db, req_ready);
					error_count++;
				end
			end
			if (lcd_e && !e_prev) begin          // Rising E, new word
				if (low_cycles < need_gap) begin
					$display("error: lcd_e low gap 0x%h cycles, expected at least 0x%h",
						low_cycles, need_gap);
					error_count++;
				end
				if (exp_rs_q.size() == 0) begin
					$display("A word appeared on the bus that no request asked for (db=0x%h)", lcd_db);
					error_count++;
					cur_cls = lcd_cmd_pkg::EXEC_LONG;
				end else begin
					if (lcd_rs !== exp_rs_q[0]) begin
						$display("error: lcd_rs 0x%h, expected 0x%h", lcd_rs, exp_rs_q[0]);
						error_count++;
					end
					if (lcd_db !== exp_db_q[0]) begin
						$display("error: lcd_db 0x%h, expected 0x%h", lcd_db, exp_db_q[0]);
						error_count++;
					end
					cur_cls = exp_cls_q[0];
					void'(exp_rs_q.pop_front());
					void'(exp_db_q.pop_front());
					void'(exp_cls_q.pop_front());
				end
				words_seen++;
				hold_rs     = lcd_rs;
				hold_db     = lcd_db;
				high_cycles = 1;
			end else if (lcd_e) begin             // Strobe continues
				high_cycles++;
				if (lcd_rs !== hold_rs || lcd_db !== hold_db) begin
					$display("error: bus moved under E, rs=0x%h db=0x%h, expected rs=0x%h db=0x%h",
						lcd_rs, lcd_db, hold_rs, hold_db);
					error_count++;
				end
			end else if (e_prev) begin            // Falling E, execution starts
				if (high_cycles != int'(lcd_timing_pkg::E_HIGH_CYCLES)) begin
					$display("error: lcd_e high 0x%h cycles, expected 0x%h",
						high_cycles, lcd_timing_pkg::E_HIGH_CYCLES);
					error_count++;
				end
				need_gap   = class_wait(cur_cls);
				low_cycles = 1;
			end else begin
				low_cycles++;
			end
			e_prev = lcd_e;
		end
	end

endmodule

//--- dv/lcd_ctrl_tb.sv
`timescale 1ns/100ps
// Testbench for the LCD controller
// Clock, reset, random request stimulus, reference model, watchdog, DUT and checker

module lcd_ctrl_tb;

	localparam int     MAX_WORDS    = 2 * lcd_cmd_pkg::INIT_LEN + 40; // Init twice plus requests
	localparam longint SLACK_CYCLES = 200;
	localparam longint WATCHDOG_NS  = 20 * (longint'(lcd_timing_pkg::POWERUP_CYCLES) +
		MAX_WORDS * (longint'(lcd_timing_pkg::E_HIGH_CYCLES) +
		longint'(lcd_timing_pkg::WAIT_LONG_CYCLES) + SLACK_CYCLES));

	logic       CLK;
	logic       RST;
	logic       req_valid;
	logic [1:0] req_oper;
	logic [7:0] req_data;
	logic       req_ready;
	logic       lcd_e;
	logic       lcd_rs;
	logic [7:0] lcd_db;

	logic [31:0] rng;        // LCG state
	logic        in_burst;   // Back-to-back character requests under way
	logic        stall_seen; // req_ready low with a request pending in a burst
	int          exp_total;  // Words handed to the checker
	int          tb_errors;
	int          err_total;

	initial CLK = 1'b0;
	always #10 CLK = !CLK;    // 20 ns period

	lcd_ctrl_top i_dut (
		.CLK       (CLK),
		.RST       (RST),
		.req_valid (req_valid),
		.req_oper  (req_oper),
		.req_data  (req_data),
		.req_ready (req_ready),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_db    (lcd_db)
	);

	lcd_bus_checker i_checker (
		.CLK         (CLK),
		.RST         (RST),
		.lcd_e       (lcd_e),
		.lcd_rs      (lcd_rs),
		.lcd_db      (lcd_db),
		.req_ready   (req_ready),
		.error_count (),
		.words_seen  ()
	);

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Highest set bit picks the execution class
	function automatic lcd_cmd_pkg::exec_class_e class_of(input logic rs, input logic [7:0] b);
		int top;
		int i;
		top = -1;
		for (i = 0; i < 8; i++)
			if (b[i]) top = i;
		if (rs) return lcd_cmd_pkg::EXEC_CHAR;
		if (top == 0 || top == 1) return lcd_cmd_pkg::EXEC_LONG;
		if (top == 5) return lcd_cmd_pkg::EXEC_FUNC;
		return lcd_cmd_pkg::EXEC_SHORT;
	endfunction

	task automatic push_word(input logic rs, input logic [7:0] b);
		i_checker.expect_word(rs, b, class_of(rs, b));
		exp_total++;
	endtask

	task automatic push_init();
		int k;
		for (k = 0; k < lcd_cmd_pkg::INIT_LEN; k++)
			push_word(1'b0, lcd_cmd_pkg::INIT_TABLE[k]);
	endtask

	// Words expected from one accepted request
	task automatic expect_request(input logic [1:0] oper, input logic [7:0] data);
		case (oper)
			lcd_cmd_pkg::OPER_CHAR:   push_word(1'b1, data);
			lcd_cmd_pkg::OPER_INSTR:  push_word(1'b0, data);
			lcd_cmd_pkg::OPER_REINIT: push_init();
			default: ;                                  // No bus word for OPER_NONE
		endcase
	endtask

	// ------------------------------------------------------------------------
	// Stimulus tasks start and end on a falling edge
	// ------------------------------------------------------------------------
	task automatic send_request(input logic [1:0] oper, input logic [7:0] data);
		logic taken;
		req_valid = 1'b1;
		req_oper  = oper;
		req_data  = data;
		taken     = 1'b0;
		while (!taken) begin
			taken = req_ready;                          // Stable since the last rise
			if (!taken && in_burst) stall_seen = 1'b1;
			@(posedge CLK);
			@(negedge CLK);
		end
		req_valid = 1'b0;
		expect_request(oper, data);
	endtask

	task automatic random_request();
		logic [1:0] oper;
		rng = lcg_next(rng);
		case (rng[17:16])
			2'd0:    oper = lcd_cmd_pkg::OPER_NONE;
			2'd2:    oper = lcd_cmd_pkg::OPER_INSTR;
			default: oper = lcd_cmd_pkg::OPER_CHAR;
		endcase
		send_request(oper, rng[31:24]);
		repeat (rng[21:20]) @(negedge CLK);           // Idle gap 0 to 3 cycles
	endtask

	task automatic char_burst(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			rng = lcg_next(rng);
			send_request(lcd_cmd_pkg::OPER_CHAR, 8'h41 + rng[28:24]);
			in_burst = 1'b1;                            // Stalls count from the second request
		end
		in_burst = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------------
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the panel bus stalled, %0d of %0d words seen",
			i_checker.words_seen, exp_total);
		$display("Checks failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		RST        = 1'b1;
		req_valid  = 1'b0;
		req_oper   = lcd_cmd_pkg::OPER_NONE;
		req_data   = 8'h00;
		rng        = 32'h4e4c_7085;
		in_burst   = 1'b0;
		stall_seen = 1'b0;
		exp_total  = 0;
		tb_errors  = 0;
		push_init();                                    // Init walk after reset
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b0;

		char_burst(8);
		send_request(lcd_cmd_pkg::OPER_INSTR, lcd_cmd_pkg::CMD_CLEAR);
		send_request(lcd_cmd_pkg::OPER_INSTR, 8'h02);   // Return home
		send_request(lcd_cmd_pkg::OPER_INSTR, 8'h38);   // Function set
		send_request(lcd_cmd_pkg::OPER_NONE, 8'h5a);
		repeat (10) random_request();
		send_request(lcd_cmd_pkg::OPER_REINIT, 8'h00);
		char_burst(8);
		send_request(lcd_cmd_pkg::OPER_INSTR, lcd_cmd_pkg::CMD_DISP_ON);
		repeat (8) random_request();

		// Drain and then wait out any stray words
		wait (i_checker.words_seen >= exp_total);
		repeat (lcd_timing_pkg::WAIT_LONG_CYCLES + SLACK_CYCLES) @(posedge CLK);
		@(negedge CLK);
		if (!stall_seen) begin
			$display("No back-pressure was seen on req_ready during the character bursts");
			tb_errors++;
		end
		if (i_checker.words_seen != exp_total) begin
			$display("error: words on bus 0x%h, expected 0x%h", i_checker.words_seen, exp_total);
			tb_errors++;
		end
		err_total = i_checker.error_count + tb_errors;
		$display("Checker errors: %0d, testbench errors: %0d, words: %0d",
			i_checker.error_count, tb_errors, i_checker.words_seen);
		if (err_total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- lcd_ctrl.f
hw/lcd_timing_pkg.sv
hw/lcd_cmd_pkg.sv
hw/lcd_sequencer.sv
hw/lcd_cmd_fifo.sv
hw/lcd_bus_writer.sv
hw/lcd_ctrl_top.sv
dv/lcd_bus_checker.sv
dv/lcd_ctrl_tb.sv

//--- Bender.yml
package:
  name: lcd_ctrl

sources:
  # RTL, packages first
  - files:
      - hw/lcd_timing_pkg.sv
      - hw/lcd_cmd_pkg.sv
      - hw/lcd_sequencer.sv
      - hw/lcd_cmd_fifo.sv
      - hw/lcd_bus_writer.sv
      - hw/lcd_ctrl_top.sv

  # Testbench
  - target: test
    files:
      - dv/lcd_bus_checker.sv
      - dv/lcd_ctrl_tb.sv
